//--- design/bp_pkg.sv
`default_nettype none

package bp_pkg;

	// Fetch address
	localparam int INST_ADDR_W = 32;
	localparam logic [INST_ADDR_W-1:0] PC_RESET = '0;

	// Pattern tables, indexed by the address bits just above the byte offset
	localparam int PRED_IDX_W   = 5;
	localparam int PRED_ENTRIES = 1 << PRED_IDX_W;
	localparam int PRED_TABLES  = 4;   // One per global history value

	// 2-bit saturating counters, also used for the history
	localparam int CTR_W = 2;
	localparam logic [CTR_W-1:0] CTR_RESET = 2'd1;   // Weakly not-taken
	localparam logic [CTR_W-1:0] CTR_MAX   = 2'd3;
	localparam logic [CTR_W-1:0] CTR_MIN   = 2'd0;

	// Statistics and register map
	localparam int CNT_W      = 16;
	localparam int CSR_ADDR_W = 2;
	localparam logic [CSR_ADDR_W-1:0] CSR_CTRL     = 2'd0;
	localparam logic [CSR_ADDR_W-1:0] CSR_BRANCHES = 2'd1;
	localparam logic [CSR_ADDR_W-1:0] CSR_MISPRED  = 2'd2;

endpackage

`default_nettype wire

//--- design/bp_update_if.sv
`timescale 1ns/100ps
`default_nettype none

// One resolved branch coming back from execute
interface bp_update_if import bp_pkg::*; ();

	logic                   valid;       // Single-cycle strobe, never refused
	logic [INST_ADDR_W-1:0] pc;          // Address of the resolved branch
	logic                   taken;       // Actual outcome
	logic                   predicted;   // Guess fetch made for this branch

	// Driven from the top-level ports
	modport src (
		output valid,
		output pc,
		output taken,
		output predicted
	);

	// Table training
	modport pred (
		input valid,
		input pc,
		input taken
	);

	// Branch and mispredict statistics
	modport stat (
		input valid,
		input taken,
		input predicted
	);

endinterface

`default_nettype wire

//--- design/branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predictor import bp_pkg::*; (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   rdy_i,
	input  wire                   pred_en_i,

	// Lookup
	input  wire [INST_ADDR_W-1:0] raddr_i,
	output logic                  pred_o,

	// Training
	bp_update_if.pred             upd
);

	logic [CTR_W-1:0]      pht [PRED_TABLES][PRED_ENTRIES];
	logic [CTR_W-1:0]      ghist;   // Saturating global history, selects the table
	logic [PRED_IDX_W-1:0] ridx;
	logic [PRED_IDX_W-1:0] widx;
	logic [CTR_W-1:0]      rd_ctr;
	logic [CTR_W-1:0]      wr_ctr;

	// One step toward the outcome, clamped at either end
	function automatic logic [CTR_W-1:0] sat_step(
		input logic [CTR_W-1:0] val,
		input logic             up
	);
		if (up) begin
			return (val == CTR_MAX) ? CTR_MAX : val + 1'b1;
		end else begin
			return (val == CTR_MIN) ? CTR_MIN : val - 1'b1;
		end
	endfunction

	// Word-aligned addresses, so drop the two byte-offset bits
	assign ridx = raddr_i[PRED_IDX_W+1:2];
	assign widx = upd.pc[PRED_IDX_W+1:2];   // Train at the branch's own address

	assign wr_ctr = pht[ghist][widx];

	always_ff @(posedge clk) begin
		if (rst) begin
			ghist <= CTR_MIN;
			for (int t = 0; t < PRED_TABLES; t++) begin
				for (int e = 0; e < PRED_ENTRIES; e++) begin
					pht[t][e] <= CTR_RESET;
				end
			end
		end else if (upd.valid) begin
			// Counter in the table chosen by the old history
			pht[ghist][widx] <= sat_step(wr_ctr, upd.taken);
			ghist            <= sat_step(ghist, upd.taken);
		end
	end

	// Same-cycle lookup, sees the state as of the last edge
	assign rd_ctr = pht[ghist][ridx];

	// Upper counter bit is the taken guess
	assign pred_o = rdy_i & pred_en_i & rd_ctr[CTR_W-1];

endmodule

`default_nettype wire

//--- design/fetch_pc.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_pc import bp_pkg::*; (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   rdy_i,
	input  wire                   redirect_i,
	input  wire [INST_ADDR_W-1:0] redirect_pc_i,
	output logic [INST_ADDR_W-1:0] pc_o
);

	logic [INST_ADDR_W-1:0] pc_q;
	logic [INST_ADDR_W-1:0] pc_next;

	// Redirect wins over the sequential step
	always_comb begin
		if (redirect_i) begin
			pc_next = redirect_pc_i;
		end else if (rdy_i) begin
			pc_next = pc_q + INST_ADDR_W'(4);   // Next word
		end else begin
			pc_next = pc_q;   // Stalled
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= PC_RESET;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- design/bp_csr.sv
`timescale 1ns/100ps
`default_nettype none

module bp_csr import bp_pkg::*; (
	input  wire                  clk,
	input  wire                  rst,

	// Register port
	input  wire                  cfg_we_i,
	input  wire [CSR_ADDR_W-1:0] cfg_addr_i,
	input  wire                  cfg_wdata_i,
	output logic [CNT_W-1:0]     cfg_rdata_o,

	// Predictor control
	output logic                 pred_en_o,

	bp_update_if.stat            upd
);

	logic             en_q;
	logic [CNT_W-1:0] br_cnt;
	logic [CNT_W-1:0] mis_cnt;
	logic             mispred;

	assign mispred = upd.predicted ^ upd.taken;

	// Enable bit, only CSR_CTRL is writable
	always_ff @(posedge clk) begin
		if (rst) begin
			en_q <= 1'b1;
		end else if (cfg_we_i && (cfg_addr_i == CSR_CTRL)) begin
			en_q <= cfg_wdata_i;
		end
	end

	// Statistics, held at all ones once full
	always_ff @(posedge clk) begin
		if (rst) begin
			br_cnt  <= '0;
			mis_cnt <= '0;
		end else if (upd.valid) begin
			if (br_cnt != '1) begin
				br_cnt <= br_cnt + 1'b1;
			end
			if (mispred && (mis_cnt != '1)) begin
				mis_cnt <= mis_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		case (cfg_addr_i)
			CSR_CTRL:     cfg_rdata_o = {{(CNT_W-1){1'b0}}, en_q};
			CSR_BRANCHES: cfg_rdata_o = br_cnt;
			CSR_MISPRED:  cfg_rdata_o = mis_cnt;
			default:      cfg_rdata_o = '0;   // Unmapped
		endcase
	end

	assign pred_en_o = en_q;

endmodule

`default_nettype wire

//--- design/bp_top.sv
`timescale 1ns/100ps
`default_nettype none

module bp_top import bp_pkg::*; (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   rdy_i,

	// Fetch redirect
	input  wire                   redirect_i,
	input  wire [INST_ADDR_W-1:0] redirect_pc_i,

	// Resolved branch from execute
	input  wire                   upd_valid_i,
	input  wire [INST_ADDR_W-1:0] upd_pc_i,
	input  wire                   upd_taken_i,
	input  wire                   upd_pred_i,

	// Register port
	input  wire                   cfg_we_i,
	input  wire [CSR_ADDR_W-1:0]  cfg_addr_i,
	input  wire                   cfg_wdata_i,
	output logic [CNT_W-1:0]      cfg_rdata_o,

	// Fetch address and its guess
	output logic [INST_ADDR_W-1:0] pc_o,
	output logic                  pred_o
);

	logic pred_en;

	bp_update_if upd_if ();

	assign upd_if.valid     = upd_valid_i;
	assign upd_if.pc        = upd_pc_i;
	assign upd_if.taken     = upd_taken_i;
	assign upd_if.predicted = upd_pred_i;

	fetch_pc u_fetch_pc (
		.clk           (clk),
		.rst           (rst),
		.rdy_i         (rdy_i),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.pc_o          (pc_o)
	);

	// Looks up the address fetch_pc presents this cycle
	branch_predictor u_predictor (
		.clk       (clk),
		.rst       (rst),
		.rdy_i     (rdy_i),
		.pred_en_i (pred_en),
		.raddr_i   (pc_o),
		.pred_o    (pred_o),
		.upd       (upd_if.pred)
	);

	bp_csr u_csr (
		.clk         (clk),
		.rst         (rst),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.cfg_rdata_o (cfg_rdata_o),
		.pred_en_o   (pred_en),
		.upd         (upd_if.stat)
	);

endmodule

`default_nettype wire

//--- dv/bp_props.sv
`timescale 1ns/100ps
`default_nettype none

module bp_props import bp_pkg::*; (
	input wire             clk,
	input wire             rst,
	input wire             rdy_i,
	input wire             pred_i,
	input wire             upd_valid_i,
	input wire             upd_taken_i,
	input wire [CTR_W-1:0] ghist_i
);

	// No guess while in reset or stalled
	a_pred_masked: assert property (@(posedge clk) (rst || !rdy_i) |-> !pred_i)
		else $error("pred_o high in reset or while rdy_i is low");

	a_hist_stable: assert property (@(posedge clk) disable iff (rst)
		!upd_valid_i |=> $stable(ghist_i))
		else $error("history moved without an update");

	a_hist_up: assert property (@(posedge clk) disable iff (rst)
		(upd_valid_i && upd_taken_i) |=> (ghist_i >= $past(ghist_i)))
		else $error("history fell after a taken update");

	a_hist_down: assert property (@(posedge clk) disable iff (rst)
		(upd_valid_i && !upd_taken_i) |=> (ghist_i <= $past(ghist_i)))
		else $error("history rose after a not-taken update");

endmodule

bind branch_predictor bp_props i_props (
	.clk         (clk),
	.rst         (rst),
	.rdy_i       (rdy_i),
	.pred_i      (pred_o),
	.upd_valid_i (upd.valid),
	.upd_taken_i (upd.taken),
	.ghist_i     (ghist)
);

`default_nettype wire

//--- dv/bp_tb.sv
`timescale 1ns/100ps
`default_nettype none

module bp_tb import bp_pkg::*; ();

	localparam logic [1:0] OP_UPD  = 2'd0;   // Resolved branch, val is the outcome
	localparam logic [1:0] OP_LOOK = 2'd1;   // Redirect fetch to addr, expv is the guess
	localparam logic [1:0] OP_WR   = 2'd2;   // CSR write, val is the data
	localparam logic [1:0] OP_RD   = 2'd3;
	localparam int NUM_ROWS = 29;

	typedef struct packed {
		logic [1:0]             op;
		logic [INST_ADDR_W-1:0] addr;
		logic                   val;
		logic [CNT_W-1:0]       expv;
	} row_t;

	logic                   clk;
	logic                   rst;
	logic                   rdy;
	logic                   redirect;
	logic [INST_ADDR_W-1:0] redirect_pc;
	logic                   upd_valid;
	logic [INST_ADDR_W-1:0] upd_pc;
	logic                   upd_taken;
	logic                   upd_pred;
	logic                   cfg_we;
	logic [CSR_ADDR_W-1:0]  cfg_addr;
	logic                   cfg_wdata;
	logic [CNT_W-1:0]       cfg_rdata;
	logic [INST_ADDR_W-1:0] pc;
	logic                   pred;

	// Reference model state
	logic [CTR_W-1:0] m_tab [PRED_TABLES][PRED_ENTRIES];
	logic [CTR_W-1:0] m_hist;
	logic             m_en;
	logic [CNT_W-1:0] m_br;
	logic [CNT_W-1:0] m_mis;

	logic [31:0] lfsr;
	int          errs;
	int          tests_ok;
	int          tests_bad;
	row_t        rows [NUM_ROWS];

	bp_top i_dut (
		.clk           (clk),
		.rst           (rst),
		.rdy_i         (rdy),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.upd_valid_i   (upd_valid),
		.upd_pc_i      (upd_pc),
		.upd_taken_i   (upd_taken),
		.upd_pred_i    (upd_pred),
		.cfg_we_i      (cfg_we),
		.cfg_addr_i    (cfg_addr),
		.cfg_wdata_i   (cfg_wdata),
		.cfg_rdata_o   (cfg_rdata),
		.pc_o          (pc),
		.pred_o        (pred)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [CTR_W-1:0] toward(input logic [CTR_W-1:0] v, input logic t);
		if (t) begin
			return (v < CTR_MAX) ? v + 1'b1 : v;
		end
		return (v > CTR_MIN) ? v - 1'b1 : v;
	endfunction

	// Counter in the table picked by the old history, then the history itself
	task automatic model_update(input logic [INST_ADDR_W-1:0] a, input logic t, input logic p);
		m_tab[m_hist][a[PRED_IDX_W+1:2]] = toward(m_tab[m_hist][a[PRED_IDX_W+1:2]], t);
		m_hist = toward(m_hist, t);
		if (m_br != '1) m_br = m_br + 1'b1;
		if ((p != t) && (m_mis != '1)) m_mis = m_mis + 1'b1;
	endtask

	function automatic logic model_pred(input logic [INST_ADDR_W-1:0] a, input logic r);
		return r & m_en & m_tab[m_hist][a[PRED_IDX_W+1:2]][CTR_W-1];
	endfunction

	function automatic logic [CNT_W-1:0] model_csr(input logic [CSR_ADDR_W-1:0] a);
		case (a)
			CSR_CTRL:     return CNT_W'(m_en);
			CSR_BRANCHES: return m_br;
			CSR_MISPRED:  return m_mis;
			default:      return '0;
		endcase
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic next_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] got, input logic [31:0] ex);
		$display("[FAIL] %s: got %h, expected %h", sig, got, ex);
		errs++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		errs++;
	endtask

	task automatic finish_test(input string name);
		if (errs == 0) begin
			$display("test %s: ok", name);
			tests_ok++;
		end else begin
			$display("test %s: %0d errors", name, errs);
			tests_bad++;
		end
		errs = 0;
	endtask

	// Starts and ends on a falling edge
	task automatic apply_row(input row_t r, input int i);
		case (r.op)
			OP_UPD: begin
				upd_valid = 1'b1;
				upd_pc    = r.addr;
				upd_taken = r.val;
				upd_pred  = 1'b0;
				@(negedge clk);
				upd_valid = 1'b0;
				model_update(r.addr, r.val, 1'b0);
			end
			OP_LOOK: begin
				redirect    = 1'b1;
				redirect_pc = r.addr;
				@(negedge clk);
				redirect = 1'b0;
				if (model_pred(r.addr, rdy) !== r.expv[0]) begin
					report_error($sformatf("model disagrees with row %0d", i));
				end
				if (pc !== r.addr) report_mismatch("pc_o", pc, r.addr);
				if (pred !== r.expv[0]) report_mismatch("pred_o", pred, r.expv[0]);
			end
			OP_WR: begin
				cfg_we    = 1'b1;
				cfg_addr  = r.addr[CSR_ADDR_W-1:0];
				cfg_wdata = r.val;
				@(negedge clk);
				cfg_we = 1'b0;
				if (r.addr[CSR_ADDR_W-1:0] == CSR_CTRL) m_en = r.val;
			end
			default: begin
				cfg_addr = r.addr[CSR_ADDR_W-1:0];
				@(negedge clk);
				if (model_csr(cfg_addr) !== r.expv) begin
					report_error($sformatf("model disagrees with row %0d", i));
				end
				if (cfg_rdata !== r.expv) report_mismatch("cfg_rdata_o", cfg_rdata, r.expv);
			end
		endcase
	endtask

	task automatic wait_for_pc(input logic [INST_ADDR_W-1:0] target, input int limit,
			output int cycles);
		cycles = 0;
		while ((pc !== target) && (cycles < limit)) begin
			@(negedge clk);
			cycles++;
		end
		if (pc !== target) begin
			report_error($sformatf("pc_o did not reach %h in %0d cycles", target, limit));
		end
	endtask

	initial begin
		int                     cyc;
		logic [INST_ADDR_W-1:0] exp_pc;
		logic [INST_ADDR_W-1:0] la;
		logic [INST_ADDR_W-1:0] ua;
		logic                   uv;
		logic                   ut;
		logic                   up;
		logic                   ur;
		rst         = 1'b1;
		rdy         = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		upd_valid   = 1'b0;
		upd_pc      = '0;
		upd_taken   = 1'b0;
		upd_pred    = 1'b0;
		cfg_we      = 1'b0;
		cfg_addr    = '0;
		cfg_wdata   = 1'b0;
		errs        = 0;
		tests_ok    = 0;
		tests_bad   = 0;
		lfsr        = 32'h8026d047;
		for (int t = 0; t < PRED_TABLES; t++) begin
			for (int e = 0; e < PRED_ENTRIES; e++) begin
				m_tab[t][e] = CTR_RESET;
			end
		end
		m_hist = CTR_MIN;
		m_en   = 1'b1;
		m_br   = '0;
		m_mis  = '0;
		// 0x40 and 0x44 sit at index 16 and 17
		rows = '{
			'{OP_UPD,  32'h40, 1'b1, 16'h0},   // t0 up, history 1
			'{OP_UPD,  32'h40, 1'b1, 16'h0},   // t1 up, history 2
			'{OP_LOOK, 32'h40, 1'b0, 16'h0},   // t2 still weakly not-taken
			'{OP_UPD,  32'h40, 1'b1, 16'h0},
			'{OP_UPD,  32'h40, 1'b1, 16'h0},
			'{OP_UPD,  32'h40, 1'b1, 16'h0},
			'{OP_UPD,  32'h40, 1'b1, 16'h0},   // t3 and history both at 3
			'{OP_LOOK, 32'h40, 1'b0, 16'h1},
			'{OP_LOOK, 32'h44, 1'b0, 16'h0},
			'{OP_WR,   32'h0,  1'b0, 16'h0},   // Predictor off
			'{OP_LOOK, 32'h40, 1'b0, 16'h0},
			'{OP_WR,   32'h1,  1'b0, 16'h0},   // Counters are read only
			'{OP_RD,   32'h1,  1'b0, 16'h6},
			'{OP_WR,   32'h0,  1'b1, 16'h0},
			'{OP_LOOK, 32'h40, 1'b0, 16'h1},
			'{OP_UPD,  32'h40, 1'b0, 16'h0},   // History drops to 2
			'{OP_LOOK, 32'h40, 1'b0, 16'h1},
			'{OP_UPD,  32'h40, 1'b0, 16'h0},
			'{OP_LOOK, 32'h40, 1'b0, 16'h1},   // t1 from the first pass
			'{OP_UPD,  32'h40, 1'b0, 16'h0},
			'{OP_LOOK, 32'h40, 1'b0, 16'h1},   // t0 from the first pass
			'{OP_UPD,  32'h40, 1'b0, 16'h0},
			'{OP_UPD,  32'h40, 1'b0, 16'h0},
			'{OP_UPD,  32'h40, 1'b0, 16'h0},   // t0 and history both at 0
			'{OP_LOOK, 32'h40, 1'b0, 16'h0},
			'{OP_RD,   32'h2,  1'b0, 16'h6},
			'{OP_RD,   32'h1,  1'b0, 16'hc},
			'{OP_RD,   32'h3,  1'b0, 16'h0},
			'{OP_RD,   32'h0,  1'b0, 16'h1}
		};
		@(negedge clk);
		rdy = 1'b1;   // Lookups run through the rest of reset
		repeat (7) @(negedge clk);
		if (pc !== PC_RESET) report_mismatch("pc_o", pc, PC_RESET);
		if (pred !== 1'b0) report_mismatch("pred_o", pred, 1'b0);
		rst = 1'b0;
		rdy = 1'b0;

		for (int a = 0; a < 4; a++) begin
			cfg_addr = a[CSR_ADDR_W-1:0];
			@(negedge clk);
			if (pc !== PC_RESET) report_mismatch("pc_o", pc, PC_RESET);
			if (cfg_rdata !== model_csr(cfg_addr)) begin
				report_mismatch("cfg_rdata_o", cfg_rdata, model_csr(cfg_addr));
			end
		end
		finish_test("reset");

		rdy    = 1'b1;
		exp_pc = PC_RESET;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			exp_pc = exp_pc + 32'd4;
			if (pc !== exp_pc) report_mismatch("pc_o", pc, exp_pc);
		end
		rdy = 1'b0;   // Stall
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			if (pc !== exp_pc) report_mismatch("pc_o", pc, exp_pc);
		end
		rdy         = 1'b1;
		redirect    = 1'b1;
		redirect_pc = 32'h200;
		@(negedge clk);
		redirect = 1'b0;
		if (pc !== 32'h200) report_mismatch("pc_o", pc, 32'h200);
		wait_for_pc(32'h210, 10, cyc);
		if (cyc != 4) report_error($sformatf("pc_o took %0d cycles to step four words", cyc));
		finish_test("pc_step");

		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(rows[i], i);
		end
		finish_test("table");

		// Each cycle redirects to a new lookup address and maybe trains
		for (int n = 0; n < 200; n++) begin
			la = rand_bits(9) << 2;
			uv = next_bit();
			ua = rand_bits(7) << 2;
			ut = next_bit();
			up = next_bit();
			ur = next_bit() | next_bit();
			rdy         = ur;
			redirect    = 1'b1;
			redirect_pc = la;
			upd_valid   = uv;
			upd_pc      = ua;
			upd_taken   = ut;
			upd_pred    = up;
			@(negedge clk);
			if (uv) model_update(ua, ut, up);
			if (pc !== la) report_mismatch("pc_o", pc, la);
			if (pred !== model_pred(la, ur)) report_mismatch("pred_o", pred, model_pred(la, ur));
		end
		redirect  = 1'b0;
		upd_valid = 1'b0;
		rdy       = 1'b1;
		cfg_addr  = CSR_BRANCHES;
		@(negedge clk);
		if (cfg_rdata !== m_br) report_mismatch("cfg_rdata_o", cfg_rdata, m_br);
		cfg_addr = CSR_MISPRED;
		@(negedge clk);
		if (cfg_rdata !== m_mis) report_mismatch("cfg_rdata_o", cfg_rdata, m_mis);
		finish_test("random");

		$display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
		if (tests_bad == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
design/bp_pkg.sv
design/bp_update_if.sv
design/branch_predictor.sv
design/fetch_pc.sv
design/bp_csr.sv
design/bp_top.sv
dv/bp_props.sv
dv/bp_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bp_tb -f filelist.f -o bp_sim \
	&& ./obj_dir/bp_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q -F '*** FAILED ***' sim.log \
	&& { echo "result: failing"; exit 1; } \
	|| { echo "result: clean"; exit 0; }
